//--- build.f
verilog/pad_pkg.sv
verilog/pad_edge_decode.sv
verilog/pad_port_sequencer.sv
verilog/pad_nibble_select.sv
verilog/pce_pad_top.sv
tb/pce_pad_asserts.sv
tb/pce_pad_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the pad testbench with Verilator, runs it and looks for the pass line.
# Exits with status 1 when the pass line is missing.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module pce_pad_tb &&
./obj_dir/Vpce_pad_tb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "run_sim: simulation passed" &&
exit 0 ||
{ echo "run_sim: simulation failed"; exit 1; }

//--- tb/pce_pad_tb.sv
//========================================
// Table-driven testbench for pce_pad_top with a cycle model
// Inputs change and joy_in is read 1 ns after the rising edge
//========================================
`timescale 1ns/1ps

module pce_pad_tb;

	import pad_pkg::*;

	localparam int num_rows  = 58;
	localparam int op_clr    = 0;  // Clear pulse
	localparam int op_sel    = 1;  // Select low, then high
	localparam int op_mouse  = 2;
	localparam int op_idle   = 3;
	localparam int op_sample = 4;  // Arg bit 0 select, bit 1 clear held
	localparam int s_lo      = 0;
	localparam int s_hi      = 1;
	localparam int s_clr     = 2;
	localparam int f_none    = 0;  // Flags {mouse_en, joy_swap, turbotap, buttons6}
	localparam int f_b6      = 1;
	localparam int f_tt      = 2;
	localparam int f_swap    = 4;
	localparam int f_mouse   = 8;

	logic clk_sys = 1'b0;
	logic arst_n;
	pad_buttons_t pad_a, pad_b, pad_2, pad_3, pad_4;
	logic joy_swap, turbotap, buttons6, mouse_en, mouse_strobe;
	mouse_delta_t mouse_x, mouse_y;
	logic [1:0] mouse_btn;
	logic [1:0] joy_out;
	pad_nibble_t joy_in;

	logic [27:0] rows [num_rows];  // Test, flags, op, arg
	string names [6];
	int m_port, m_step, m_timer;
	logic m_bank;
	logic [7:0] m_pend_x, m_pend_y, m_ms_x, m_ms_y;
	logic [1:0] m_last;
	int checks, errors, test_checks, test_errors, tests_passed, tests_failed;

	pce_pad_top pce_pad_top_i (.*);

	bind pad_port_sequencer pce_pad_asserts pce_pad_asserts_i (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.clr       (clr),
		.turbotap  (turbotap),
		.buttons6  (buttons6),
		.high_bank (high_bank),
		.port      (port)
	);

	always #4 clk_sys = ~clk_sys;

	function automatic logic [27:0] row(input int test, input int flags, input int op,
		input int arg);
		row = {4'(test), 4'(flags), 4'(op), 16'(arg)};
	endfunction

	// One clock edge of the reference model, then the 1 ns drive offset
	task automatic tick();
		logic clr_rise;
		logic sel_rise;
		logic timer_full;
		@(posedge clk_sys);
		clr_rise = joy_out[1] & ~m_last[1];
		sel_rise = joy_out[0] & ~m_last[0] & ~joy_out[1];
		timer_full = (m_timer == (1 << mouse_timeout_bits) - 1);
		if (joy_out[1]) m_port = 0;
		else if (sel_rise && turbotap) m_port = (m_port + 1) % 8;
		if (clr_rise) m_bank = buttons6 & ~m_bank;
		if (clr_rise && m_step == 3) begin  // Byte finished
			m_ms_x = m_pend_x;
			m_ms_y = m_pend_y;
			m_pend_x = 8'h00;
			m_pend_y = 8'h00;
		end
		if (mouse_strobe) begin
			m_pend_x = -mouse_x;
			m_pend_y = mouse_y;
		end
		if (clr_rise) m_step = (m_step + 1) % 4;
		else if (timer_full) m_step = 3;
		if (joy_out[1]) m_timer = 0;
		else if (!timer_full) m_timer++;
		m_last = joy_out;
		#1;
	endtask

	function automatic logic [3:0] expected_nibble();
		pad_buttons_t p0;
		pad_buttons_t pad;
		logic [3:0] hi;
		int idx;
		p0 = joy_swap ? pad_b : pad_a;
		idx = 2 * m_bank + joy_out[0];
		if (joy_out[1]) return 4'h0;
		if (m_port == 0 && mouse_en) begin
			case (m_step)
				0: hi = m_ms_x[7:4];
				1: hi = m_ms_x[3:0];
				2: hi = m_ms_y[7:4];
				default: hi = m_ms_y[3:0];
			endcase
			return idx[0] ? hi : ~{p0[7], p0[6], mouse_btn[0], mouse_btn[1]};
		end
		if (m_port >= num_ports) return idle_word[idx*4 +: 4];
		case (m_port)
			0: pad = p0;
			1: pad = joy_swap ? pad_a : pad_b;
			2: pad = pad_2;
			3: pad = pad_3;
			default: pad = pad_4;
		endcase
		case (idx)
			0: return ~pad[7:4];
			1: return ~{pad[1], pad[2], pad[0], pad[3]};  // Down, left, up, right
			2: return ~pad[11:8];
			default: return 4'h0;
		endcase
	endfunction

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		test_checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic apply_row(input logic [27:0] r);
		{mouse_en, joy_swap, turbotap, buttons6} = r[23:20];
		case (int'(r[19:16]))
			op_clr: begin
				joy_out[1] = 1'b1;
				tick();
				joy_out[1] = 1'b0;
			end
			op_sel: begin
				joy_out[0] = 1'b0;
				repeat (2) tick();
				joy_out[0] = 1'b1;
			end
			op_mouse: begin
				mouse_x = mouse_delta_t'($urandom_range(255, 1));  // Never a zero X delta
				mouse_y = mouse_delta_t'($urandom);
				mouse_strobe = 1'b1;
				tick();
				mouse_strobe = 1'b0;
			end
			op_idle: repeat (int'(r[15:0])) tick();
			default: joy_out = r[1:0];
		endcase
		repeat (3) tick();
	endtask

	task automatic report_test(input int t);
		$display("Test %s: %0d checks, %0d failed", names[t], test_checks, test_errors);
		if (test_errors == 0) tests_passed++;
		else tests_failed++;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		{joy_swap, turbotap, buttons6, mouse_en, mouse_strobe} = '0;
		{mouse_x, mouse_y, joy_out} = '0;
		pad_a = pad_buttons_t'($urandom(32'hac210682));  // Seeds the generator
		pad_b = pad_buttons_t'($urandom);
		pad_2 = pad_buttons_t'($urandom);
		pad_3 = pad_buttons_t'($urandom);
		pad_4 = pad_buttons_t'($urandom);
		mouse_btn = 2'($urandom);
		{m_port, m_step, m_timer, m_bank, m_last} = '0;
		{m_pend_x, m_pend_y, m_ms_x, m_ms_y} = '0;
		names = '{"basic_read", "six_button", "multitap", "swap", "mouse", "timeout"};
		rows = '{
			row(0, f_none, op_clr, 0), row(0, f_none, op_sample, s_lo),
			row(0, f_none, op_sample, s_hi), row(0, f_none, op_sample, s_clr),
			row(1, f_b6, op_clr, 0), row(1, f_b6, op_sample, s_lo), row(1, f_b6, op_sample, s_hi),
			row(1, f_b6, op_clr, 0), row(1, f_b6, op_sample, s_lo), row(1, f_b6, op_clr, 0),
			row(1, f_b6, op_sample, s_hi), row(1, f_none, op_clr, 0),
			row(1, f_none, op_sample, s_hi), row(1, f_none, op_clr, 0),
			row(1, f_none, op_sample, s_lo),
			row(2, f_tt, op_clr, 0), row(2, f_tt, op_sample, s_lo), row(2, f_tt, op_sample, s_hi),
			row(2, f_tt, op_sample, s_lo), row(2, f_tt, op_sample, s_hi),
			row(2, f_tt, op_sample, s_lo), row(2, f_tt, op_sample, s_hi),
			row(2, f_tt, op_sample, s_lo), row(2, f_tt, op_sample, s_hi),
			row(2, f_tt, op_sample, s_lo), row(2, f_tt, op_sample, s_hi),
			row(2, f_tt, op_sample, s_lo), row(2, f_none, op_sample, s_hi),
			row(2, f_none, op_clr, 0), row(2, f_none, op_sample, s_lo),
			row(2, f_none, op_sample, s_hi),
			row(3, f_tt | f_swap, op_clr, 0), row(3, f_tt | f_swap, op_sample, s_lo),
			row(3, f_tt | f_swap, op_sel, 0), row(3, f_tt | f_swap, op_sample, s_hi),
			row(3, f_tt | f_swap, op_sample, s_lo),
			row(4, f_mouse, op_mouse, 0), row(4, f_mouse, op_clr, 0),
			row(4, f_mouse, op_sample, s_lo), row(4, f_mouse, op_sample, s_hi),
			row(4, f_mouse, op_clr, 0), row(4, f_mouse, op_sample, s_hi),
			row(4, f_mouse, op_clr, 0), row(4, f_mouse, op_sample, s_hi),
			row(4, f_mouse, op_clr, 0), row(4, f_mouse, op_sample, s_hi),
			row(4, f_mouse, op_clr, 0), row(4, f_mouse, op_sample, s_hi),
			row(4, f_mouse, op_clr, 0), row(4, f_mouse, op_sample, s_hi),
			row(4, f_mouse, op_clr, 0), row(4, f_mouse, op_sample, s_hi),
			row(5, f_mouse, op_mouse, 0), row(5, f_mouse, op_idle, 33000),
			row(5, f_mouse, op_clr, 0), row(5, f_mouse, op_sample, s_hi),
			row(5, f_mouse, op_clr, 0), row(5, f_mouse, op_sample, s_hi)
		};
		arst_n = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1 arst_n = 1'b1;
		check_value(8'(joy_in), 8'h00, "joy_in after reset");
		for (int i = 0; i < num_rows; i++) begin
			apply_row(rows[i]);
			if (int'(rows[i][19:16]) == op_sample) begin
				check_value(8'(joy_in), 8'(expected_nibble()),
					$sformatf("%s row %0d", names[rows[i][27:24]], i));
				if (rows[i][1]) begin  // Let go of a held clear
					joy_out[1] = 1'b0;
					repeat (3) tick();
				end
			end
			if (i == num_rows - 1 || rows[i+1][27:24] != rows[i][27:24]) begin
				report_test(int'(rows[i][27:24]));
			end
		end
		$display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (num_rows * 50 + 40000) @(posedge clk_sys);
		$display("Simulation timed out before the test table finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tb/pce_pad_asserts.sv
//========================================
// Bound into pad_port_sequencer
// Checks are off while arst_n is low
//========================================
`timescale 1ns/1ps

module pce_pad_asserts (
	input logic           clk_sys,
	input logic           arst_n,
	input logic           clr,
	input logic           turbotap,
	input logic           buttons6,
	input logic           high_bank,
	input pad_pkg::port_t port
);

	// Only clear may move the port when turbotap is off
	port_held: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!turbotap && !clr) |=> $stable(port))
		else $error("port moved while turbotap was low");

	port_cleared: assert property (@(posedge clk_sys) disable iff (!arst_n)
		clr |=> (port == '0))
		else $error("port not 0 one cycle after clear");

	bank_low: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!buttons6 && !high_bank) |=> !high_bank)
		else $error("high_bank set while buttons6 was low");

endmodule

//--- verilog/pce_pad_top.sv
//========================================
// All inputs must be synchronous to clk_sys
// joy_in follows joy_out after two edges
//========================================
`timescale 1ns/1ps

module pce_pad_top (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  pad_pkg::pad_buttons_t pad_a,
	input  pad_pkg::pad_buttons_t pad_b,
	input  pad_pkg::pad_buttons_t pad_2,
	input  pad_pkg::pad_buttons_t pad_3,
	input  pad_pkg::pad_buttons_t pad_4,
	input  logic                  joy_swap,
	input  logic                  turbotap,
	input  logic                  buttons6,
	input  logic                  mouse_en,
	input  pad_pkg::mouse_delta_t mouse_x,
	input  pad_pkg::mouse_delta_t mouse_y,
	input  logic [1:0]            mouse_btn,
	input  logic                  mouse_strobe,
	input  logic [1:0]            joy_out,
	output pad_pkg::pad_nibble_t  joy_in
);

	import pad_pkg::*;

	logic         clr_rise;
	logic         sel_rise;
	logic         clr;
	port_t        port;
	logic         high_bank;
	mouse_step_t  mouse_step;
	mouse_delta_t ms_x;
	mouse_delta_t ms_y;

	pad_edge_decode pad_edge_decode_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.joy_out  (joy_out),
		.clr_rise (clr_rise),
		.sel_rise (sel_rise),
		.clr      (clr)
	);

	pad_port_sequencer pad_port_sequencer_i (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.clr          (clr),
		.clr_rise     (clr_rise),
		.sel_rise     (sel_rise),
		.buttons6     (buttons6),
		.turbotap     (turbotap),
		.mouse_strobe (mouse_strobe),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.port         (port),
		.high_bank    (high_bank),
		.mouse_step   (mouse_step),
		.ms_x         (ms_x),
		.ms_y         (ms_y)
	);

	pad_nibble_select pad_nibble_select_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.pad_a      (pad_a),
		.pad_b      (pad_b),
		.pad_2      (pad_2),
		.pad_3      (pad_3),
		.pad_4      (pad_4),
		.joy_swap   (joy_swap),
		.mouse_en   (mouse_en),
		.mouse_btn  (mouse_btn),
		.clr        (clr),
		.sel        (joy_out[0]),  // Select level picks the nibble
		.port       (port),
		.high_bank  (high_bank),
		.mouse_step (mouse_step),
		.ms_x       (ms_x),
		.ms_y       (ms_y),
		.joy_in     (joy_in)
	);

endmodule

//--- verilog/pad_nibble_select.sv
//========================================
// joy_in is active low and registered
// Mouse replaces port 0 only while mouse_en is set
//========================================
`timescale 1ns/1ps

module pad_nibble_select (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  pad_pkg::pad_buttons_t pad_a,
	input  pad_pkg::pad_buttons_t pad_b,
	input  pad_pkg::pad_buttons_t pad_2,
	input  pad_pkg::pad_buttons_t pad_3,
	input  pad_pkg::pad_buttons_t pad_4,
	input  logic                  joy_swap,
	input  logic                  mouse_en,
	input  logic [1:0]            mouse_btn,   // Bit 0 left, bit 1 right
	input  logic                  clr,
	input  logic                  sel,
	input  pad_pkg::port_t        port,
	input  logic                  high_bank,
	input  pad_pkg::mouse_step_t  mouse_step,
	input  pad_pkg::mouse_delta_t ms_x,
	input  pad_pkg::mouse_delta_t ms_y,
	output pad_pkg::pad_nibble_t  joy_in
);

	import pad_pkg::*;

	pad_buttons_t pad_0;
	pad_buttons_t pad_1;
	pad_buttons_t pads [num_ports];
	logic [3:0]   mouse_hi;
	logic [7:0]   mouse_byte;
	pad_word_t    port_word;
	logic [1:0]   nib_idx;

	// Nibble 3 is always 0, directions reordered for the console
	function automatic pad_word_t to_word(input pad_buttons_t b);
		to_word = ~{4'hF, b[11:8], b[1], b[2], b[0], b[3], b[7:4]};
	endfunction

	assign pad_0 = joy_swap ? pad_b : pad_a;
	assign pad_1 = joy_swap ? pad_a : pad_b;
	assign pads  = '{pad_0, pad_1, pad_2, pad_3, pad_4};

	//========================================
	// Mouse byte
	//========================================

	always_comb begin
		case (mouse_step)
			2'd0:    mouse_hi = ms_x[7:4];
			2'd1:    mouse_hi = ms_x[3:0];
			2'd2:    mouse_hi = ms_y[7:4];
			default: mouse_hi = ms_y[3:0];
		endcase
	end

	assign mouse_byte = {mouse_hi, ~{pad_0[7:6], mouse_btn[0], mouse_btn[1]}};

	//========================================
	// Port word and output latch
	//========================================

	always_comb begin
		port_word = idle_word;  // Past the last port
		for (int i = 0; i < num_ports; i++) begin
			if (port == port_t'(i)) begin
				port_word = (i == 0 && mouse_en) ? {mouse_byte, mouse_byte} : to_word(pads[i]);
			end
		end
	end

	assign nib_idx = {high_bank, sel};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joy_in <= '0;
		end else if (clr) begin
			joy_in <= '0;
		end else begin
			joy_in <= port_word[{nib_idx, 2'b00} +: 4];
		end
	end

endmodule

//--- verilog/pad_port_sequencer.sv
//========================================
// State advances one edge after a strobe
// Port only steps with turbotap; bank only toggles with buttons6
//========================================
`timescale 1ns/1ps

module pad_port_sequencer (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  clr,
	input  logic                  clr_rise,
	input  logic                  sel_rise,
	input  logic                  buttons6,
	input  logic                  turbotap,
	input  logic                  mouse_strobe,
	input  pad_pkg::mouse_delta_t mouse_x,
	input  pad_pkg::mouse_delta_t mouse_y,
	output pad_pkg::port_t        port,
	output logic                  high_bank,
	output pad_pkg::mouse_step_t  mouse_step,
	output pad_pkg::mouse_delta_t ms_x,
	output pad_pkg::mouse_delta_t ms_y
);

	import pad_pkg::*;

	mouse_timer_t mouse_timer;
	logic         timer_done;
	mouse_delta_t pend_x;      // Collected since the last byte
	mouse_delta_t pend_y;
	logic         byte_done;   // Clear edge on the last nibble

	assign timer_done = &mouse_timer;  // Saturated
	assign byte_done  = clr_rise && (mouse_step == mouse_last_step);

	//========================================
	// Multitap port and button bank
	//========================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			port      <= '0;
			high_bank <= 1'b0;
		end else if (clr) begin
			port <= '0;
			if (clr_rise) begin
				high_bank <= buttons6 & ~high_bank;  // Six-button pads alternate
			end
		end else if (sel_rise && turbotap) begin
			port <= port + 1'b1;
		end
	end

	//========================================
	// Mouse counter and inactivity timer
	//========================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mouse_timer <= '0;
		end else if (clr) begin
			mouse_timer <= '0;  // Console is polling
		end else if (!timer_done) begin
			mouse_timer <= mouse_timer + 1'b1;
		end
	end

	// A timeout parks the counter so the next clear edge wraps to 0
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mouse_step <= '0;
		end else if (clr_rise) begin
			mouse_step <= mouse_step + 1'b1;
		end else if (timer_done) begin
			mouse_step <= mouse_last_step;
		end
	end

	//========================================
	// Mouse deltas
	//========================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pend_x <= '0;
			pend_y <= '0;
		end else if (mouse_strobe) begin
			pend_x <= -mouse_x;  // Console X runs the other way
			pend_y <= mouse_y;
		end else if (byte_done) begin
			pend_x <= '0;
			pend_y <= '0;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ms_x <= '0;
			ms_y <= '0;
		end else if (byte_done) begin
			ms_x <= pend_x;  // Stable for the whole next byte
			ms_y <= pend_y;
		end
	end

endmodule

//--- verilog/pad_edge_decode.sv
//========================================
// joy_out must already be synchronous to clk_sys
// Select edges are ignored while clear is high
//========================================
`timescale 1ns/1ps

module pad_edge_decode (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic [1:0] joy_out,   // Bit 0 select, bit 1 clear
	output logic       clr_rise,
	output logic       sel_rise,
	output logic       clr
);

	logic [1:0] last_out;  // Lines from the previous cycle

	//========================================
	// Previous line state
	//========================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			last_out <= 2'b00;
		end else begin
			last_out <= joy_out;
		end
	end

	//========================================
	// Edge strobes
	//========================================

	assign clr = joy_out[1];

	// One cycle per rising edge
	assign clr_rise = joy_out[1] & ~last_out[1];

	// Clear has priority, so a select edge under clear is dropped here
	assign sel_rise = joy_out[0] & ~last_out[0] & ~joy_out[1];

endmodule

//--- verilog/pad_pkg.sv
//========================================
// Widths and constants for the pad port logic
// Host joystick words are active high; the console nibble is active low
//========================================
package pad_pkg;

	//========================================
	// Constants
	//========================================

	localparam int num_ports          = 5;   // Multitap ports
	localparam int mouse_timeout_bits = 15;  // Inactivity timer width

	//========================================
	// Types
	//========================================

	// Bits 3:0 right, left, down, up
	// Bits 7:4 I, II, select, run
	// Bits 11:8 III to VI
	typedef logic [11:0] pad_buttons_t;

	typedef logic [15:0] pad_word_t;    // Four nibbles as the console reads them
	typedef logic [3:0]  pad_nibble_t;  // Pad input to the console

	typedef logic [2:0] port_t;  // Multitap port number

	typedef logic signed [7:0] mouse_delta_t;
	typedef logic [1:0]        mouse_step_t;  // Mouse nibble counter
	typedef logic [mouse_timeout_bits-1:0] mouse_timer_t;

	//========================================
	// Typed constants
	//========================================

	// Read from any port past the last one
	localparam pad_word_t idle_word = 16'h0FFF;

	// Last nibble of a mouse byte, also the re-arm value after a timeout
	localparam mouse_step_t mouse_last_step = 2'd3;

endpackage
